// File: rp_pkg.sv
// shared widths, bus map, data types and code conversions; imported by every rp RTL module
`default_nettype none

package rp_pkg;

  //////////////////////////////
  // widths and counts
  //////////////////////////////
  localparam int SAMPLE_W  = 14;             // ADC and DAC sample width
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int LED_W     = 8;
  localparam int N_PWM     = 4;              // PWM analog outputs
  localparam int PWM_W     = 8;              // duty and period counter width
  localparam int PWM_IDX_W = $clog2(N_PWM);

  //////////////////////////////
  // address map
  //////////////////////////////
  localparam int REGION_LSB = 20;            // region field sits at addr[22:20]
  localparam int REGION_W   = 3;
  localparam int N_REGIONS  = 8;
  localparam logic [REGION_W-1:0] REGION_HK  = 3'd0;
  localparam logic [REGION_W-1:0] REGION_PWM = 3'd4;

  // housekeeping offsets, low 20 address bits
  localparam logic [REGION_LSB-1:0] OFS_ID      = 20'h0_0000;  // read only
  localparam logic [REGION_LSB-1:0] OFS_LOOP    = 20'h0_0004;
  localparam logic [REGION_LSB-1:0] OFS_LED     = 20'h0_0008;
  localparam logic [REGION_LSB-1:0] OFS_LEVEL_A = 20'h0_0010;
  localparam logic [REGION_LSB-1:0] OFS_LEVEL_B = 20'h0_0014;
  localparam logic [REGION_LSB-1:0] OFS_FEED    = 20'h0_0018;
  localparam logic [REGION_LSB-1:0] OFS_PWM0    = 20'h0_0020;  // duty k at +4*k

  localparam logic [DATA_W-1:0] RP_ID = 32'h5250_0001;

  //////////////////////////////
  // data types
  //////////////////////////////
  typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement
  typedef logic        [SAMPLE_W-1:0] raw_t;     // neg-slope offset binary

  localparam raw_t RAW_MID  = 14'h2000;   // ADC register code out of reset
  localparam raw_t RAW_ZERO = 14'h1FFF;   // DAC code of sample 0

  typedef struct packed { sample_t a; sample_t b; } sample_pair_t;  // 28 bits
  typedef struct packed { raw_t    a; raw_t    b; } raw_pair_t;     // 28 bits

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              wen;    // one-cycle write strobe
    logic              ren;    // one-cycle read strobe
  } sys_req_t;                 // 66 bits

  typedef struct packed {
    logic [DATA_W-1:0] rdata;  // valid with ack
    logic              ack;
  } sys_rsp_t;                 // 33 bits

  // sign bit kept, magnitude bits flipped for the negative slope
  function automatic sample_t raw_to_sample(input raw_t raw);
    return {raw[SAMPLE_W-1], ~raw[SAMPLE_W-2:0]};
  endfunction

  function automatic raw_t sample_to_raw(input sample_t smp);
    return {smp[SAMPLE_W-1], ~smp[SAMPLE_W-2:0]};  // same mapping, it is its own inverse
  endfunction

endpackage

`default_nettype wire

// File: adc_frontend.sv
// ADC capture stage; registers raw converter words and hands signed samples, or DAC loopback, onward
`timescale 1ns/1ps
`default_nettype none

module adc_frontend
  import rp_pkg::*;
(
  input  wire               adc_clk,
  input  wire               arst_n_i,
  input  wire raw_pair_t    adc_raw_i,       // straight from the ADC pins
  input  wire sample_pair_t dac_sample_i,    // stage-1 DAC samples
  input  wire               digital_loop_i,  // 1: feed DAC stream back
  output sample_pair_t      adc_sample_o
);

  raw_pair_t    adc_raw_q;    // pin capture registers
  sample_pair_t adc_conv;     // converted capture

  //////////////////////////////
  // pin capture
  //////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      adc_raw_q.a <= RAW_MID;   // mid-scale code
      adc_raw_q.b <= RAW_MID;
    end
    else
    begin
      adc_raw_q <= adc_raw_i;
    end
  end

  // neg-slope offset binary into two's complement
  assign adc_conv.a = raw_to_sample(adc_raw_q.a);
  assign adc_conv.b = raw_to_sample(adc_raw_q.b);

  // loopback select, no extra register here
  always_comb
  begin
    if (digital_loop_i)
      adc_sample_o = dac_sample_i;   // previous cycle's saturated sum
    else
      adc_sample_o = adc_conv;
  end

endmodule

`default_nettype wire

// File: dac_backend.sv
// DAC output stage; sums level and feed-through, saturates, registers and converts to DAC codes
`timescale 1ns/1ps
`default_nettype none

module dac_backend
  import rp_pkg::*;
(
  input  wire               adc_clk,
  input  wire               arst_n_i,
  input  wire sample_pair_t adc_sample_i,  // converted ADC or loopback
  input  wire sample_pair_t level_i,       // generator levels from hk
  input  wire [1:0]         feed_en_i,     // [0] channel a, [1] channel b
  output sample_pair_t      dac_sample_o,  // stage-1 value, also to loopback
  output raw_pair_t         dac_raw_o
);

  sample_pair_t sum_d;      // saturated sums
  sample_pair_t stage1_q;
  raw_pair_t    stage2_q;

  // level plus optional feed-through, clipped to the 14-bit range
  function automatic sample_t sat_sum(input sample_t lvl, input sample_t smp, input logic en);
    sample_t           term;
    logic [SAMPLE_W:0] sum;   // one guard bit
    term = en ? smp : '0;
    sum  = {lvl[SAMPLE_W-1], lvl} + {term[SAMPLE_W-1], term};
    if (sum[SAMPLE_W] != sum[SAMPLE_W-1])
      return {sum[SAMPLE_W], {(SAMPLE_W-1){~sum[SAMPLE_W]}}};  // +8191 or -8192
    return sum[SAMPLE_W-1:0];
  endfunction

  assign sum_d.a = sat_sum(level_i.a, adc_sample_i.a, feed_en_i[0]);
  assign sum_d.b = sat_sum(level_i.b, adc_sample_i.b, feed_en_i[1]);

  //////////////////////////////
  // two output stages
  //////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      stage1_q    <= '0;        // sample 0 on both channels
      stage2_q.a  <= RAW_ZERO;
      stage2_q.b  <= RAW_ZERO;
    end
    else
    begin
      stage1_q    <= sum_d;
      stage2_q.a  <= sample_to_raw(stage1_q.a);  // back to neg-slope code
      stage2_q.b  <= sample_to_raw(stage1_q.b);
    end
  end

  assign dac_sample_o = stage1_q;
  assign dac_raw_o    = stage2_q;   // parallel channels, no interleave

endmodule

`default_nettype wire

// File: sys_bus_decoder.sv
// system bus decoder; splits addr[22:20] into eight regions and merges the slave answers
`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder
  import rp_pkg::*;
(
  input  wire sys_req_t sys_req_i,   // from bus master
  output sys_req_t      hk_req_o,    // region 0
  output sys_req_t      pwm_req_o,   // region 4
  input  wire sys_rsp_t hk_rsp_i,
  input  wire sys_rsp_t pwm_rsp_i,
  output sys_rsp_t      sys_rsp_o
);

  logic [REGION_W-1:0]  region;
  logic [N_REGIONS-1:0] sel;         // one-hot region select
  logic                 strobe;
  logic                 unused_hit;  // strobe into an empty region

  // pass address and data through, keep strobes only for the chosen slave
  function automatic sys_req_t gate_req(input sys_req_t req, input logic en);
    sys_req_t res;
    res     = req;
    res.wen = req.wen & en;
    res.ren = req.ren & en;
    return res;
  endfunction

  //////////////////////////////
  // region select
  //////////////////////////////
  assign region = sys_req_i.addr[REGION_LSB +: REGION_W];
  assign sel    = {{(N_REGIONS-1){1'b0}}, 1'b1} << region;
  assign strobe = sys_req_i.wen | sys_req_i.ren;

  assign hk_req_o  = gate_req(sys_req_i, sel[REGION_HK]);
  assign pwm_req_o = gate_req(sys_req_i, sel[REGION_PWM]);

  // regions 1..3 and 5..7 have no slave
  assign unused_hit = strobe & ~(sel[REGION_HK] | sel[REGION_PWM]);

  //////////////////////////////
  // response merge
  //////////////////////////////
  // mapped slaves answer one cycle late, when addr may already have moved on,
  // so each answer is picked by its own ack rather than by the address
  always_comb
  begin
    sys_rsp_o.ack   = hk_rsp_i.ack | pwm_rsp_i.ack | unused_hit;  // empty regions ack at once
    sys_rsp_o.rdata = ({DATA_W{hk_rsp_i.ack}}  & hk_rsp_i.rdata)
                    | ({DATA_W{pwm_rsp_i.ack}} & pwm_rsp_i.rdata);  // zero otherwise
  end

endmodule

`default_nettype wire

// File: hk_regs.sv
// housekeeping register region 0; ID, loopback, LEDs, generator levels and feed-through enables
`timescale 1ns/1ps
`default_nettype none

module hk_regs
  import rp_pkg::*;
(
  input  wire               adc_clk,
  input  wire               arst_n_i,
  input  wire sys_req_t     req_i,           // strobes already gated by decoder
  output sys_rsp_t          rsp_o,
  output logic              digital_loop_o,
  output logic [LED_W-1:0]  led_o,
  output sample_pair_t      level_o,
  output logic [1:0]        feed_en_o
);

  logic [REGION_LSB-1:0] ofs;      // offset inside the region
  logic [DATA_W-1:0]     rd_val;   // read mux

  logic                  loop_q;
  logic [LED_W-1:0]      led_q;
  sample_pair_t          level_q;  // generator stand-in
  logic [1:0]            feed_q;
  sys_rsp_t              rsp_q;

  assign ofs = req_i.addr[REGION_LSB-1:0];

  //////////////////////////////
  // register writes
  //////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_q  <= 1'b0;
      led_q   <= '0;
      level_q <= '0;
      feed_q  <= '0;
    end
    else if (req_i.wen)
    begin
      case (ofs)
        OFS_LOOP:    loop_q    <= req_i.wdata[0];
        OFS_LED:     led_q     <= req_i.wdata[LED_W-1:0];
        OFS_LEVEL_A: level_q.a <= req_i.wdata[SAMPLE_W-1:0];
        OFS_LEVEL_B: level_q.b <= req_i.wdata[SAMPLE_W-1:0];
        OFS_FEED:    feed_q    <= req_i.wdata[1:0];
        default:     ;   // ID and holes ignore writes
      endcase
    end
  end

  // readback, zero-extended
  always_comb
  begin
    case (ofs)
      OFS_ID:      rd_val = RP_ID;
      OFS_LOOP:    rd_val = {{(DATA_W-1){1'b0}}, loop_q};
      OFS_LED:     rd_val = {{(DATA_W-LED_W){1'b0}}, led_q};
      OFS_LEVEL_A: rd_val = {{(DATA_W-SAMPLE_W){1'b0}}, level_q.a};
      OFS_LEVEL_B: rd_val = {{(DATA_W-SAMPLE_W){1'b0}}, level_q.b};
      OFS_FEED:    rd_val = {{(DATA_W-2){1'b0}}, feed_q};
      default:     rd_val = '0;   // unmapped offsets read zero
    endcase
  end

  //////////////////////////////
  // bus answer
  //////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rsp_q <= '0;
    end
    else
    begin
      rsp_q.ack   <= req_i.wen | req_i.ren;            // one cycle after strobe
      rsp_q.rdata <= req_i.ren ? rd_val : '0;
    end
  end

  assign rsp_o          = rsp_q;
  assign digital_loop_o = loop_q;
  assign led_o          = led_q;
  assign level_o        = level_q;
  assign feed_en_o      = feed_q;

endmodule

`default_nettype wire

// File: pwm_dac.sv
// PWM analog outputs in region 4; duty registers on the bus and a shared period counter
`timescale 1ns/1ps
`default_nettype none

module pwm_dac
  import rp_pkg::*;
(
  input  wire           adc_clk,
  input  wire           arst_n_i,
  input  wire sys_req_t req_i,
  output sys_rsp_t      rsp_o,
  output logic [N_PWM-1:0] pwm_o
);

  logic [REGION_LSB-1:0]        rel;      // offset from first duty register
  logic                         in_map;
  logic [PWM_IDX_W-1:0]         idx;      // duty channel addressed
  logic [N_PWM-1:0][PWM_W-1:0]  duty_q;
  logic [PWM_W-1:0]             cnt_q;    // period counter, wraps at 256
  logic [N_PWM-1:0]             pwm_q;
  sys_rsp_t                     rsp_q;

  // word-aligned hits on OFS_PWM0 .. OFS_PWM0 + 4*(N_PWM-1)
  assign rel    = req_i.addr[REGION_LSB-1:0] - OFS_PWM0;
  assign in_map = (rel[REGION_LSB-1:PWM_IDX_W+2] == '0) && (rel[1:0] == 2'b00);
  assign idx    = rel[PWM_IDX_W+1:2];

  //////////////////////////////
  // duty registers and bus
  //////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      duty_q <= '0;
      rsp_q  <= '0;
    end
    else
    begin
      if (req_i.wen && in_map)
        duty_q[idx] <= req_i.wdata[PWM_W-1:0];
      rsp_q.ack   <= req_i.wen | req_i.ren;   // also for holes
      rsp_q.rdata <= (req_i.ren && in_map) ? {{(DATA_W-PWM_W){1'b0}}, duty_q[idx]} : '0;
    end
  end

  //////////////////////////////
  // period counter and compare
  //////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cnt_q <= '0;
      pwm_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;   // free running
      for (int k = 0; k < N_PWM; k++)
        pwm_q[k] <= (cnt_q < duty_q[k]);   // duty 255 leaves one low cycle
    end
  end

  assign rsp_o = rsp_q;
  assign pwm_o = pwm_q;

endmodule

`default_nettype wire

// File: rp_top.sv
// top of the fast analog path; ADC capture, DAC output, bus decoder and the two register regions
`timescale 1ns/1ps
`default_nettype none

module rp_top
  import rp_pkg::*;
(
  input  wire               adc_clk,
  input  wire               arst_n_i,
  input  wire raw_pair_t    adc_raw_i,   // ADC pins, both channels
  input  wire sys_req_t     sys_req_i,   // bus master
  output sys_rsp_t          sys_rsp_o,
  output raw_pair_t         dac_raw_o,   // DAC pins, parallel channels
  output logic [LED_W-1:0]  led_o,
  output logic [N_PWM-1:0]  pwm_o
);

  sys_req_t     hk_req, pwm_req;   // per-region requests
  sys_rsp_t     hk_rsp, pwm_rsp;
  logic         digital_loop;
  sample_pair_t level;             // generator levels
  logic [1:0]   feed_en;
  sample_pair_t adc_sample;        // front end to back end
  sample_pair_t dac_sample;        // loopback path

  //////////////////////////////
  // data path
  //////////////////////////////
  adc_frontend i_adc (
    .adc_clk        (adc_clk     ),
    .arst_n_i       (arst_n_i    ),
    .adc_raw_i      (adc_raw_i   ),
    .dac_sample_i   (dac_sample  ),
    .digital_loop_i (digital_loop),
    .adc_sample_o   (adc_sample  )
  );

  dac_backend i_dac (
    .adc_clk        (adc_clk     ),
    .arst_n_i       (arst_n_i    ),
    .adc_sample_i   (adc_sample  ),
    .level_i        (level       ),
    .feed_en_i      (feed_en     ),
    .dac_sample_o   (dac_sample  ),
    .dac_raw_o      (dac_raw_o   )
  );

  //////////////////////////////
  // register bus
  //////////////////////////////
  sys_bus_decoder i_dec (
    .sys_req_i      (sys_req_i   ),
    .hk_req_o       (hk_req      ),
    .pwm_req_o      (pwm_req     ),
    .hk_rsp_i       (hk_rsp      ),
    .pwm_rsp_i      (pwm_rsp     ),
    .sys_rsp_o      (sys_rsp_o   )
  );

  hk_regs i_hk (
    .adc_clk        (adc_clk     ),
    .arst_n_i       (arst_n_i    ),
    .req_i          (hk_req      ),   // region 0
    .rsp_o          (hk_rsp      ),
    .digital_loop_o (digital_loop),
    .led_o          (led_o       ),
    .level_o        (level       ),
    .feed_en_o      (feed_en     )
  );

  pwm_dac i_pwm (
    .adc_clk        (adc_clk     ),
    .arst_n_i       (arst_n_i    ),
    .req_i          (pwm_req     ),   // region 4
    .rsp_o          (pwm_rsp     ),
    .pwm_o          (pwm_o       )
  );

endmodule

`default_nettype wire

// File: rp_props.sv
// bus, reset and PWM counter properties; attached to rp_top by the bind statement at the bottom
`timescale 1ns/1ps
`default_nettype none

module rp_props
  import rp_pkg::*;
(
  input wire             adc_clk,
  input wire             arst_n_i,
  input wire sys_req_t   sys_req_i,
  input wire sys_rsp_t   sys_rsp_i,
  input wire raw_pair_t  dac_raw_i,
  input wire [PWM_W-1:0] pwm_cnt_i    // shared period counter
);

  int   fail_cnt = 0;                 // read by the testbench at the end
  logic strobe;

  assign strobe = sys_req_i.wen | sys_req_i.ren;

  // ack only in the strobe cycle or the one after
  ack_needs_strobe: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $rose(sys_rsp_i.ack) |-> (strobe || $past(strobe)))
  else
  begin
    fail_cnt++;
    $error("ack rose with no strobe in this or the previous cycle");
  end

  dac_idle_in_reset: assert property (@(posedge adc_clk)
    !arst_n_i |-> (dac_raw_i == {14'h1FFF, 14'h1FFF}))
  else
  begin
    fail_cnt++;
    $error("DAC code is not mid-scale while reset is asserted");
  end

  pwm_cnt_steps: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $past(arst_n_i) |-> (pwm_cnt_i == $past(pwm_cnt_i) + 8'd1))   // wraps at 256
  else
  begin
    fail_cnt++;
    $error("PWM period counter did not advance by one");
  end

endmodule

bind rp_top rp_props props_i (
  .adc_clk   (adc_clk    ),
  .arst_n_i  (arst_n_i   ),
  .sys_req_i (sys_req_i  ),
  .sys_rsp_i (sys_rsp_o  ),
  .dac_raw_i (dac_raw_o  ),
  .pwm_cnt_i (i_pwm.cnt_q)
);

`default_nettype wire

// File: tb_rp_top.sv
// testbench for rp_top; runs bus register access, ADC-to-DAC stream, saturation, loopback and PWM checks
`timescale 1ns/1ps
`default_nettype none

module tb_rp_top
  import rp_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int N_ROUNDS   = 4;             // feed-through stream rounds
  localparam int STREAM_LEN = 32;
  localparam int SAT_LEN    = 8;
  localparam int TEST_CYCLES = 4 + 40 * 3 + N_ROUNDS * (STREAM_LEN + 20)
                             + 2 * (SAT_LEN + 20) + 40 + 280;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;
  localparam logic [31:0] HK_BASE  = 32'h4000_0000;   // region 0
  localparam logic [31:0] PWM_BASE = 32'h4040_0000;   // region 4
  localparam int DUTY [4] = '{0, 1, 128, 255};

  logic               adc_clk;
  logic               arst_n;
  raw_pair_t          adc_raw;
  sys_req_t           sys_req;
  sys_rsp_t           sys_rsp;
  raw_pair_t          dac_raw;
  logic [7:0]         led;
  logic [3:0]         pwm;

  logic [31:0]        lfsr_q;
  int                 cyc = 0;                  // rising edges seen
  int                 err_cnt [3] = '{0, 0, 0}; // bus, data path, pwm
  raw_pair_t          exp_q [$];                // expected DAC codes
  int                 due_q [$];                // cycle each one shows up
  raw_pair_t          cmp_exp;
  logic signed [13:0] lvl_a;                    // copies of the level registers
  logic signed [13:0] lvl_b;
  logic [1:0]         feed_m;

  rp_top rp_top_i (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n ),
    .adc_raw_i (adc_raw),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp),
    .dac_raw_o (dac_raw),
    .led_o     (led    ),
    .pwm_o     (pwm    )
  );

  initial adc_clk = 1'b0;
  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  always @(posedge adc_clk) cyc <= cyc + 1;

  //////////////////////////////
  // random bits and reference model
  //////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];  // taps 32,22,2,1
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // negative slope so code 0 is positive full scale
  function automatic int code_to_sample(input logic [13:0] code);
    return 8191 - int'(code);
  endfunction

  function automatic logic [13:0] sample_to_code(input int smp);
    int c;
    c = 8191 - smp;
    return c[13:0];
  endfunction

  function automatic int clamp_sum(input int lvl, input int smp);
    int s;
    s = lvl + smp;
    if (s > 8191)
      s = 8191;
    if (s < -8192)
      s = -8192;
    return s;
  endfunction

  function automatic raw_pair_t dac_expect(input raw_pair_t raw);
    raw_pair_t e;
    int        in_a;
    int        in_b;
    in_a = feed_m[0] ? code_to_sample(raw.a) : 0;   // feed-through off adds zero
    in_b = feed_m[1] ? code_to_sample(raw.b) : 0;
    e.a  = sample_to_code(clamp_sum(int'(lvl_a), in_a));
    e.b  = sample_to_code(clamp_sum(int'(lvl_b), in_b));
    return e;
  endfunction

  //////////////////////////////
  // checks and bus tasks
  //////////////////////////////
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp,
                           input int cat);
    assert (got === exp)
    else
    begin
      err_cnt[cat]++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_problem(input string msg, input int cat);
    err_cnt[cat]++;
    $display("ERROR: %s at %0t", msg, $time);
  endtask

  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int lat;
    int exp_lat;
    exp_lat = (addr[22:20] == 3'd0 || addr[22:20] == 3'd4) ? 1 : 0;  // mapped slaves ack late
    lat     = 0;
    @(posedge adc_clk);
    #2;
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = wr;
    sys_req.ren   = ~wr;
    @(negedge adc_clk);
    while (!sys_rsp.ack && lat < 4)
    begin
      @(posedge adc_clk);
      #2;
      sys_req.wen = 1'b0;   // strobe lasts one cycle
      sys_req.ren = 1'b0;
      lat++;
      @(negedge adc_clk);
    end
    rdata = sys_rsp.rdata;
    if (!sys_rsp.ack)
      report_problem($sformatf("no ack within 4 cycles for address 0x%08h", addr), 0);
    else
      check_val("sys_rsp_o.ack latency", lat, exp_lat, 0);
    if (lat == 0)
    begin
      @(posedge adc_clk);
      #2;
      sys_req.wen = 1'b0;
      sys_req.ren = 1'b0;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rd_unused;
    bus_access(1'b1, addr, wdata, rd_unused);
  endtask

  task automatic bus_read_check(input string name, input logic [31:0] addr,
                                input logic [31:0] exp);
    logic [31:0] rd;
    bus_access(1'b0, addr, 32'h0, rd);
    check_val(name, rd, exp, 0);
  endtask

  task automatic set_config(input logic [1:0] feed);
    feed_m = feed;
    bus_write(HK_BASE + 32'h10, {18'h0, lvl_a});
    bus_write(HK_BASE + 32'h14, {18'h0, lvl_b});
    bus_write(HK_BASE + 32'h18, {30'h0, feed});
  endtask

  //////////////////////////////
  // data path stimulus and compare
  //////////////////////////////
  task automatic drive_sample(input raw_pair_t raw);
    @(posedge adc_clk);
    #2;
    adc_raw = raw;
    exp_q.push_back(dac_expect(raw));
    due_q.push_back(cyc + 3);   // capture, stage 1, stage 2
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (due_q.size() > 0 && n < 8)
    begin
      @(negedge adc_clk);
      n++;
    end
    if (due_q.size() > 0)
      report_problem("expected DAC values were never compared", 1);
  endtask

  always @(negedge adc_clk)
  begin
    while (due_q.size() > 0 && due_q[0] <= cyc)
    begin
      cmp_exp = exp_q.pop_front();
      void'(due_q.pop_front());
      check_val("dac_raw_o.a", dac_raw.a, cmp_exp.a, 1);
      check_val("dac_raw_o.b", dac_raw.b, cmp_exp.b, 1);
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial
  begin
    int exp_a;
    int exp_b;
    int high [4];
    int total;
    lfsr_q  = 32'h1a6c_68ee;
    arst_n  = 1'b1;
    adc_raw = {14'h2000, 14'h2000};
    sys_req = '0;
    lvl_a   = '0;
    lvl_b   = '0;
    feed_m  = '0;
    #1;
    arst_n = 1'b0;
    repeat (3) @(posedge adc_clk);
    #2;
    arst_n = 1'b1;
    @(negedge adc_clk);
    check_val("dac_raw_o.a", dac_raw.a, 14'h1FFF, 1);   // sample 0
    check_val("dac_raw_o.b", dac_raw.b, 14'h1FFF, 1);
    check_val("pwm_o", pwm, 4'h0, 2);
    check_val("led_o", led, 8'h00, 0);

    // register map with the upper bits of each write dropped
    bus_read_check("ID", HK_BASE, 32'h5250_0001);
    bus_write(HK_BASE, 32'hDEAD_BEEF);                  // read-only
    bus_read_check("ID", HK_BASE, 32'h5250_0001);
    bus_write(HK_BASE + 32'h04, 32'hFFFF_FFFF);
    bus_read_check("loopback", HK_BASE + 32'h04, 32'h1);
    bus_write(HK_BASE + 32'h08, 32'hFFFF_FFA5);
    bus_read_check("LED", HK_BASE + 32'h08, 32'hA5);
    check_val("led_o", led, 8'hA5, 0);
    bus_write(HK_BASE + 32'h10, 32'hFFFF_1234);
    bus_read_check("level a", HK_BASE + 32'h10, 32'h1234);
    bus_write(HK_BASE + 32'h14, 32'h0000_EABC);
    bus_read_check("level b", HK_BASE + 32'h14, 32'h2ABC);
    bus_write(HK_BASE + 32'h18, 32'hFFFF_FFFF);
    bus_read_check("feed enables", HK_BASE + 32'h18, 32'h3);
    bus_read_check("hk hole", HK_BASE + 32'h0C, 32'h0);
    bus_write(HK_BASE + 32'h04, 32'h0);
    set_config(2'b00);                                  // levels back to 0
    for (int k = 0; k < 4; k++)
    begin
      bus_write(PWM_BASE + 32'h20 + 4 * k, 32'hFFFF_FF3C + k);
      bus_read_check($sformatf("duty %0d", k), PWM_BASE + 32'h20 + 4 * k, 32'h3C + k);
    end
    bus_read_check("pwm hole", PWM_BASE + 32'h30, 32'h0);
    for (int r = 1; r < 8; r++)
      if (r != 4)
        bus_read_check("unused region", HK_BASE | {9'h0, 3'(r), 20'h0}, 32'h0);
    bus_write(HK_BASE | 32'h0020_0000, 32'h1234_5678);  // region 2 has no slave

    // feed-through stream with random enables after the first round
    for (int r = 0; r < N_ROUNDS; r++)
    begin
      lvl_a = 14'(rand_bits(14));
      lvl_b = 14'(rand_bits(14));
      set_config((r == 0) ? 2'b11 : 2'(rand_bits(2)));
      for (int i = 0; i < STREAM_LEN; i++)
        drive_sample({14'(rand_bits(14)), 14'(rand_bits(14))});
      wait_drain();
    end

    // both rails and then swapped
    lvl_a = 14'sh1FFF;
    lvl_b = 14'sh2000;
    set_config(2'b11);
    repeat (SAT_LEN) drive_sample({14'h0000, 14'h3FFF});   // +8191 and -8192 in
    wait_drain();
    check_val("dac_raw_o.a", dac_raw.a, 14'h0000, 1);
    check_val("dac_raw_o.b", dac_raw.b, 14'h3FFF, 1);
    lvl_a = 14'sh2000;
    lvl_b = 14'sh1FFF;
    set_config(2'b11);
    repeat (SAT_LEN) drive_sample({14'h3FFF, 14'h0000});
    wait_drain();
    check_val("dac_raw_o.a", dac_raw.a, 14'h3FFF, 1);
    check_val("dac_raw_o.b", dac_raw.b, 14'h0000, 1);

    // loopback where stage 1 settles on the levels before feed-through closes the loop
    lvl_a = 14'sd1000;
    lvl_b = -14'sd1000;
    set_config(2'b00);
    bus_write(HK_BASE + 32'h04, 32'h1);
    bus_write(HK_BASE + 32'h18, 32'h3);
    exp_a = 0;
    exp_b = 0;
    repeat (12)
    begin
      @(negedge adc_clk);
      exp_a = clamp_sum(int'(lvl_a), exp_a);   // one level step per cycle
      exp_b = clamp_sum(int'(lvl_b), exp_b);
      check_val("dac_raw_o.a", dac_raw.a, sample_to_code(exp_a), 1);
      check_val("dac_raw_o.b", dac_raw.b, sample_to_code(exp_b), 1);
    end
    repeat (4)
    begin
      @(negedge adc_clk);
      check_val("dac_raw_o.a", dac_raw.a, 14'h0000, 1);
      check_val("dac_raw_o.b", dac_raw.b, 14'h3FFF, 1);
    end
    bus_write(HK_BASE + 32'h04, 32'h0);
    bus_write(HK_BASE + 32'h18, 32'h0);

    // PWM high count over one full period
    for (int k = 0; k < 4; k++)
      bus_write(PWM_BASE + 32'h20 + 4 * k, DUTY[k]);
    repeat (2) @(posedge adc_clk);
    high = '{0, 0, 0, 0};
    repeat (256)
    begin
      @(negedge adc_clk);
      for (int k = 0; k < 4; k++)
        high[k] += int'(pwm[k]);
    end
    for (int k = 0; k < 4; k++)
      check_val($sformatf("pwm_o[%0d] high count", k), high[k], DUTY[k], 2);

    total = err_cnt[0] + err_cnt[1] + err_cnt[2] + rp_top_i.props_i.fail_cnt;
    $display("errors: bus %0d, data path %0d, pwm %0d, assertions %0d",
             err_cnt[0], err_cnt[1], err_cnt[2], rp_top_i.props_i.fail_cnt);
    if (total == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // watchdog sized from the test lengths above
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
rp_pkg.sv
adc_frontend.sv
dac_backend.sv
sys_bus_decoder.sv
hk_regs.sv
pwm_dac.sv
rp_top.sv
rp_props.sv
tb_rp_top.sv

// File: Makefile
# Verilator build and run of the rp_top testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+1000
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
